//--- verification/gate_testdata.hex
// Per record: 3 x pairs {weight,operand}, 5 r pairs {weight,operand}, bias, expected a(l)
// All words Q4.12 hex, one record per neuron, four records per run

// Run 0, linear tanh region and floor shift
// in 271.5 -> 271, rec 34.5 -> 34, bias 256, s 561
10000100 0800FFFF 10000010
10000040 1000FFE0 00001234 08000003 10000001
0100 0231
// in -255.5 -> -256, rec -61.5 -> -62, bias -128, s -446
1000FF00 08000001 10000000
1000FFC0 08000005 00000000 00000000 00000000
FF80 FE42
// About +0.3, in 768, rec 384, bias 85, s 1237
10000200 10000100 00000000
10000100 20000040 00000000 00000000 00000000
0055 04D5
// About -0.3, s -1237
1000FE00 1000FF00 00000000
1000FF00 2000FFC0 00000000 00000000 00000000
FFAB FB2B

// Run 1, half slope and clamp segments
// About +1.0, s 4097, 1024 + 2048
10000800 00000000 00000000
10000400 00000000 00000000 00000000 00000000
0401 0C00
// About -1.0, s -4097
1000F800 00000000 00000000
1000FC00 00000000 00000000 00000000 00000000
FBFF F400
// About +2.5, s 10240, clamp
10001000 10000800 00000000
10001000 00000000 00000000 00000000 00000000
0000 1000
// About -2.5, s -10240, clamp
1000F000 1000F800 00000000
1000F000 00000000 00000000 00000000 00000000
0000 F000

// Run 2, lane and sum saturation, segment edges
// Both lanes and bias at max, sum saturates
7FFF7FFF 7FFF7FFF 7FFF7FFF
7FFF7FFF 7FFF7FFF 7FFF7FFF 7FFF7FFF 7FFF7FFF
7FFF 1000
// Both lanes and bias at min, sum saturates
7FFF8000 7FFF8000 7FFF8000
80007FFF 80007FFF 80007FFF 80007FFF 80007FFF
8000 F000
// s exactly 0.5, still identity
10000400 00000000 00000000
10000300 00000000 00000000 00000000 00000000
0100 0800
// s -2051, magnitude 2051 halves to 1025
1000FC00 00000000 00000000
1000FD00 00000000 00000000 00000000 00000000
FEFD F7FF

//--- tb.f
hdl/ntm_gate_pkg.sv
hdl/ntm_dot_lane.sv
hdl/ntm_gate_combiner.sv
hdl/ntm_activation_gate_vector.sv
verification/tb_clock_gen.sv
verification/tb_activation_gate.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the activation gate testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_activation_gate -f tb.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_tb 2>&1)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -q "All tests passed"; then
  exit 0
else
  echo "Pass message not found"
  exit 1
fi

//--- verification/tb_activation_gate.sv
// Activation gate vector testbench
`timescale 1ns/1ps
`default_nettype none

module tb_activation_gate;

  localparam int NEURONS     = 4;
  localparam int INPUTS      = 3;
  localparam int REC_LEN     = 5;
  localparam int RUNS        = 3;                          // Vectors in the data file
  localparam int NREC        = RUNS * NEURONS;             // One record per neuron
  localparam int REC_WORDS   = INPUTS + REC_LEN + 2;       // Pairs, bias, expected
  localparam int MAX_GAP     = 3;                          // Idle cycles before a pair
  localparam int BIAS_GAP    = 12;                         // Bias lands first or last
  localparam int CYCLE_LIMIT = NREC * (INPUTS + REC_LEN + 1) * (BIAS_GAP + 2) + 200;

  //////////////////////////////
  // DUT signals
  //////////////////////////////

  logic                    CLK;
  logic                    RST;
  logic                    start;
  logic                    x_valid;
  ntm_gate_pkg::in_pair_t  x_pair;
  logic                    r_valid;
  ntm_gate_pkg::rec_pair_t r_pair;
  logic                    b_valid;
  ntm_gate_pkg::q_t        bias;
  logic                    a_valid;
  ntm_gate_pkg::gate_out_t a_out;
  logic                    ready;

  logic [31:0] mem [NREC*REC_WORDS];  // Whole data file
  integer      seed = 32'hbb6;
  int          done_count = 0;        // Results seen so far
  int          cycles = 0;

  tb_clock_gen #(.PERIOD_NS(8)) clk_gen (.CLK(CLK));

  ntm_activation_gate_vector #(
    .NEURONS (NEURONS),
    .INPUTS  (INPUTS),
    .REC_LEN (REC_LEN)
  ) uut (
    .CLK     (CLK),
    .RST     (RST),
    .start   (start),
    .x_valid (x_valid),
    .x_pair  (x_pair),
    .r_valid (r_valid),
    .r_pair  (r_pair),
    .b_valid (b_valid),
    .bias    (bias),
    .a_valid (a_valid),
    .a_out   (a_out),
    .ready   (ready)
  );

  //////////////////////////////
  // Reporting and checks
  //////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_gate_out(input ntm_gate_pkg::gate_out_t got,
                                input ntm_gate_pkg::gate_out_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %0t: a_out index %0d value %0d, expected index %0d value %0d",
                          $time, got.index, $signed(got.value),
                          exp.index, $signed(exp.value)));
    end
  endtask

  task automatic check_ready(input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %0t: ready is %b, expected %b after %0d results",
                          $time, got, exp, done_count));
    end
  endtask

  // Index from record position, value straight from the file
  function automatic ntm_gate_pkg::gate_out_t expected_out(input int rec);
    ntm_gate_pkg::gate_out_t e;
    e.index = ntm_gate_pkg::IDX_W'(rec % NEURONS);
    e.value = mem[rec*REC_WORDS + REC_WORDS - 1][15:0];
    return e;
  endfunction

  // Every word present, every expected value within the tanh range
  task automatic scan_testdata();
    int i;
    ntm_gate_pkg::q_t v;
    for (i = 0; i < NREC*REC_WORDS; i++) begin
      if ($isunknown(mem[i])) begin
        abort_run("test data file is missing or too short");
      end
    end
    for (i = 0; i < NREC; i++) begin
      v = mem[i*REC_WORDS + REC_WORDS - 1][15:0];
      if (v > ntm_gate_pkg::Q_ONE || v < -ntm_gate_pkg::Q_ONE) begin
        abort_run("test data holds an expected value outside the tanh range");
      end
    end
  endtask

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  function automatic int pick_gap(input int max_gap);
    return $unsigned($random(seed)) % (max_gap + 1);
  endfunction

  // Sampled at posedge, count moves on negedge
  task automatic wait_done(input int target);
    while (done_count < target) begin
      @(posedge CLK);
    end
  endtask

  task automatic pulse_start();
    @(negedge CLK);
    start = 1'b1;
    @(negedge CLK);
    start = 1'b0;
  endtask

  task automatic feed_inputs(input int rec);
    int i;
    int base;
    base = rec * REC_WORDS;
    for (i = 0; i < INPUTS; i++) begin
      repeat (pick_gap(MAX_GAP)) @(negedge CLK);
      x_valid = 1'b1;
      x_pair  = ntm_gate_pkg::in_pair_t'(mem[base + i]);
      @(negedge CLK);
      x_valid = 1'b0;
    end
  endtask

  task automatic feed_recurrent(input int rec);
    int i;
    int base;
    base = rec * REC_WORDS + INPUTS;  // r then h, already flattened
    for (i = 0; i < REC_LEN; i++) begin
      repeat (pick_gap(MAX_GAP)) @(negedge CLK);
      r_valid = 1'b1;
      r_pair  = ntm_gate_pkg::rec_pair_t'(mem[base + i]);
      @(negedge CLK);
      r_valid = 1'b0;
    end
  endtask

  task automatic feed_bias(input int rec);
    repeat (pick_gap(BIAS_GAP)) @(negedge CLK);
    b_valid = 1'b1;
    bias    = ntm_gate_pkg::q_t'(mem[rec*REC_WORDS + INPUTS + REC_LEN][15:0]);
    @(negedge CLK);
    b_valid = 1'b0;
  endtask

  //////////////////////////////
  // Result monitor
  //////////////////////////////

  // Outputs settle after posedge, read them half a cycle later
  always @(negedge CLK) begin
    if (a_valid === 1'b1) begin
      if (done_count >= NREC) begin
        abort_run("a_valid pulsed after the last record");
      end
      check_gate_out(a_out, expected_out(done_count));
      check_ready(ready, (done_count % NEURONS) == NEURONS - 1);  // Last neuron only
      done_count = done_count + 1;
    end else begin
      check_ready(ready, 1'b0);  // Never alone
    end
  end

  always @(posedge CLK) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      abort_run("timeout: result never arrived");
    end
  end

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    int run;
    int n;
    int rec;
    RST     = 1'b1;
    start   = 1'b0;
    x_valid = 1'b0;
    x_pair  = '0;
    r_valid = 1'b0;
    r_pair  = '0;
    b_valid = 1'b0;
    bias    = '0;
    $readmemh("verification/gate_testdata.hex", mem);
    scan_testdata();

    repeat (5) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;

    for (run = 0; run < RUNS; run++) begin
      wait_done(run * NEURONS);  // Previous vector finished with ready
      pulse_start();
      for (n = 0; n < NEURONS; n++) begin
        rec = run * NEURONS + n;
        wait_done(rec);          // One neuron in flight
        @(negedge CLK);
        fork
          feed_inputs(rec);
          feed_recurrent(rec);
          feed_bias(rec);
        join
      end
    end

    wait_done(NREC);
    repeat (4) @(negedge CLK);  // Room for a stray strobe
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
// Testbench clock source
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS = 8  // Full clock period
) (
  output logic CLK
);

  // Low first, rising edge after half a period
  initial begin
    CLK = 1'b0;
  end

  always #(PERIOD_NS / 2) CLK = ~CLK;

endmodule

`default_nettype wire

//--- hdl/ntm_activation_gate_vector.sv
// NTM activation gate top level
`timescale 1ns/1ps
`default_nettype none

module ntm_activation_gate_vector #(
  parameter int NEURONS = 4,  // Gate outputs per vector
  parameter int INPUTS  = 3,  // W*x stream length
  parameter int REC_LEN = 5   // K*r + U*h stream length
) (
  input  logic                    CLK,
  input  logic                    RST,
  input  logic                    start,
  input  logic                    x_valid,
  input  ntm_gate_pkg::in_pair_t  x_pair,
  input  logic                    r_valid,
  input  ntm_gate_pkg::rec_pair_t r_pair,
  input  logic                    b_valid,
  input  ntm_gate_pkg::q_t        bias,
  output logic                    a_valid,
  output ntm_gate_pkg::gate_out_t a_out,
  output logic                    ready
);

  // Lane results into the combiner
  logic             in_sum_valid;
  ntm_gate_pkg::q_t in_sum;
  logic             rec_sum_valid;
  ntm_gate_pkg::q_t rec_sum;

  //////////////////////////////
  // Lanes
  //////////////////////////////

  ntm_dot_lane #(
    .COUNT  (INPUTS),
    .pair_t (ntm_gate_pkg::in_pair_t)
  ) input_lane (
    .CLK       (CLK),
    .RST       (RST),
    .start     (start),
    .valid     (x_valid),
    .pair      (x_pair),
    .sum_valid (in_sum_valid),
    .sum       (in_sum)
  );

  // r and h arrive as one flattened stream
  ntm_dot_lane #(
    .COUNT  (REC_LEN),
    .pair_t (ntm_gate_pkg::rec_pair_t)
  ) recurrent_lane (
    .CLK       (CLK),
    .RST       (RST),
    .start     (start),
    .valid     (r_valid),
    .pair      (r_pair),
    .sum_valid (rec_sum_valid),
    .sum       (rec_sum)
  );

  //////////////////////////////
  // Combiner
  //////////////////////////////

  ntm_gate_combiner #(
    .NEURONS (NEURONS)
  ) combiner (
    .CLK           (CLK),
    .RST           (RST),
    .start         (start),
    .in_sum_valid  (in_sum_valid),
    .in_sum        (in_sum),
    .rec_sum_valid (rec_sum_valid),
    .rec_sum       (rec_sum),
    .b_valid       (b_valid),   // Bias straight from host
    .bias          (bias),
    .a_valid       (a_valid),
    .a_out         (a_out),
    .ready         (ready)
  );

endmodule

`default_nettype wire

//--- hdl/ntm_gate_combiner.sv
// Gate sum, tanh and neuron control
`timescale 1ns/1ps
`default_nettype none

module ntm_gate_combiner #(
  parameter int NEURONS = 4  // Outputs per vector
) (
  input  logic                    CLK,
  input  logic                    RST,
  input  logic                    start,
  input  logic                    in_sum_valid,   // W*x done
  input  ntm_gate_pkg::q_t        in_sum,
  input  logic                    rec_sum_valid,  // K*r + U*h done
  input  ntm_gate_pkg::q_t        rec_sum,
  input  logic                    b_valid,        // Bias from host
  input  ntm_gate_pkg::q_t        bias,
  output logic                    a_valid,
  output ntm_gate_pkg::gate_out_t a_out,
  output logic                    ready           // With last neuron
);

  typedef enum logic {
    IDLE,
    BUSY
  } state_t;

  //////////////////////////////
  // Signals
  //////////////////////////////

  state_t                         state;
  logic [ntm_gate_pkg::IDX_W-1:0] idx;          // Current neuron
  logic                           in_have;      // Present flags
  logic                           rec_have;
  logic                           b_have;
  ntm_gate_pkg::q_t               in_reg;       // Operand holding regs
  ntm_gate_pkg::q_t               rec_reg;
  ntm_gate_pkg::q_t               b_reg;
  ntm_gate_pkg::q_t               in_cur;       // Arriving or held value
  ntm_gate_pkg::q_t               rec_cur;
  ntm_gate_pkg::q_t               b_cur;
  logic                           busy;
  logic                           complete;     // Third operand in this cycle
  logic                           last_neuron;
  logic signed [ntm_gate_pkg::Q_W+1:0] sum_w;   // Two guard bits for 3 terms
  ntm_gate_pkg::q_t               s_sat;
  logic                           s_neg;
  logic signed [ntm_gate_pkg::Q_W:0]   s_abs;   // Holds +32768
  logic signed [ntm_gate_pkg::Q_W:0]   mag;     // Half-slope segment
  logic signed [ntm_gate_pkg::Q_W:0]   mag_neg;
  ntm_gate_pkg::q_t               tanh_val;

  //////////////////////////////
  // Sum and PWL tanh
  //////////////////////////////

  always_comb begin
    busy    = (state == BUSY);
    in_cur  = in_sum_valid  ? in_sum  : in_reg;
    rec_cur = rec_sum_valid ? rec_sum : rec_reg;
    b_cur   = b_valid       ? bias    : b_reg;
    complete = busy && (in_have || in_sum_valid) && (rec_have || rec_sum_valid)
               && (b_have || b_valid);
    last_neuron = (idx == ntm_gate_pkg::IDX_W'(NEURONS - 1));

    sum_w = in_cur + rec_cur + b_cur;
    s_sat = ntm_gate_pkg::sat_q(sum_w);
    s_neg = s_sat[ntm_gate_pkg::Q_W-1];
    s_abs = s_neg ? -s_sat : s_sat;  // Magnitude, 17 bits

    // 0.25 + |s|/2, meets identity at 0.5 and 1.0 at 1.5
    mag     = (ntm_gate_pkg::Q_ONE >>> 2) + (s_abs >>> 1);
    mag_neg = -mag;

    if (s_abs <= (ntm_gate_pkg::Q_ONE >>> 1)) begin
      tanh_val = s_sat;  // Linear core
    end else if (s_abs <= ntm_gate_pkg::Q_ONE + (ntm_gate_pkg::Q_ONE >>> 1)) begin
      tanh_val = s_neg ? mag_neg[ntm_gate_pkg::Q_W-1:0] : mag[ntm_gate_pkg::Q_W-1:0];
    end else begin
      tanh_val = s_neg ? -ntm_gate_pkg::Q_ONE : ntm_gate_pkg::Q_ONE;  // Clamp
    end
  end

  //////////////////////////////
  // FSM and flags
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= IDLE;
      idx      <= '0;
      in_have  <= 1'b0;
      rec_have <= 1'b0;
      b_have   <= 1'b0;
      a_valid  <= 1'b0;
      ready    <= 1'b0;
    end else begin
      a_valid <= complete;
      ready   <= complete && last_neuron;
      if (!busy) begin
        if (start) begin
          state    <= BUSY;
          idx      <= '0;
          in_have  <= 1'b0;
          rec_have <= 1'b0;
          b_have   <= 1'b0;
        end
      end else if (complete) begin
        // Neuron done, flags free for the next one
        in_have  <= 1'b0;
        rec_have <= 1'b0;
        b_have   <= 1'b0;
        if (last_neuron) begin
          state <= IDLE;
          idx   <= '0;
        end else begin
          idx <= idx + 1'b1;
        end
      end else begin
        in_have  <= in_have  | in_sum_valid;
        rec_have <= rec_have | rec_sum_valid;
        b_have   <= b_have   | b_valid;
      end
    end
  end

  // Operand and result words
  always_ff @(posedge CLK) begin
    in_reg  <= in_cur;
    rec_reg <= rec_cur;
    b_reg   <= b_cur;
    if (complete) begin
      a_out <= '{index: idx, value: tanh_val};
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  // One neuron in flight, host waits for a_valid
  a_no_double_arrival: assert property (
    @(posedge CLK) disable iff (RST)
    !((in_sum_valid && in_have) || (rec_sum_valid && rec_have) || (b_valid && b_have))
  ) else $error("ntm_gate_combiner: operand arrived twice for one neuron");

  a_no_idle_arrival: assert property (
    @(posedge CLK) disable iff (RST)
    (in_sum_valid || rec_sum_valid || b_valid) |-> busy
  ) else $error("ntm_gate_combiner: operand arrived while idle");

  a_start_when_idle: assert property (
    @(posedge CLK) disable iff (RST)
    start |-> !busy
  ) else $error("ntm_gate_combiner: start while busy");

endmodule

`default_nettype wire

//--- hdl/ntm_dot_lane.sv
// Multiply-accumulate dot product lane
`timescale 1ns/1ps
`default_nettype none

module ntm_dot_lane #(
  parameter int  COUNT  = 3,                          // Stream length per neuron
  parameter type pair_t = ntm_gate_pkg::in_pair_t     // Weight/operand element
) (
  input  logic             CLK,
  input  logic             RST,
  input  logic             start,      // New vector, clear lane
  input  logic             valid,      // One strobe per element
  input  pair_t            pair,
  output logic             sum_valid,  // One cycle after the last element
  output ntm_gate_pkg::q_t sum
);

  localparam int CNT_W = (COUNT > 1) ? $clog2(COUNT) : 1;

  //////////////////////////////
  // Signals
  //////////////////////////////

  logic [CNT_W-1:0]                      cnt;       // Elements taken so far
  logic signed [ntm_gate_pkg::ACC_W-1:0] acc;
  logic signed [ntm_gate_pkg::ACC_W-1:0] acc_next;  // Including current product
  logic signed [ntm_gate_pkg::ACC_W-1:0] acc_shr;   // Back to Q4.12 scale
  logic signed [2*ntm_gate_pkg::Q_W-1:0] prod;      // Full Q8.24 product
  logic                                  last;

  //////////////////////////////
  // Datapath
  //////////////////////////////

  always_comb begin
    prod     = pair.weight * pair.operand;  // Both fields signed
    acc_next = acc + prod;                  // Sign extended to ACC_W
    // Arithmetic shift rounds toward minus infinity
    acc_shr  = acc_next >>> ntm_gate_pkg::FRAC_W;
    last     = valid && (cnt == CNT_W'(COUNT - 1));
  end

  //////////////////////////////
  // Control
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      cnt       <= '0;
      acc       <= '0;
      sum_valid <= 1'b0;
    end else begin
      sum_valid <= last;  // Strobe follows the COUNT-th element
      if (start || last) begin
        // New vector, or ready for the next neuron right away
        cnt <= '0;
        acc <= '0;
      end else if (valid) begin
        cnt <= cnt + 1'b1;
        acc <= acc_next;
      end
    end
  end

  // Result word, only meaningful with sum_valid
  always_ff @(posedge CLK) begin
    if (last) begin
      sum <= ntm_gate_pkg::sat_q(acc_shr);
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  // Host keeps element strobes away from the start pulse
  a_no_valid_on_start: assert property (
    @(posedge CLK) disable iff (RST)
    start |-> !valid
  ) else $error("ntm_dot_lane: valid together with start");

endmodule

`default_nettype wire

//--- hdl/ntm_gate_pkg.sv
// Activation gate shared types
`default_nettype none

package ntm_gate_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  localparam int Q_W    = 16;  // Data word
  localparam int FRAC_W = 12;  // Q4.12 fraction bits
  localparam int ACC_W  = 40;  // 32-bit products plus guard bits
  localparam int IDX_W  = 8;   // Up to 256 neurons

  //////////////////////////////
  // Fixed point
  //////////////////////////////

  typedef logic signed [Q_W-1:0] q_t;

  localparam q_t Q_ONE = 16'sd4096;      // 1.0 in Q4.12
  localparam q_t Q_MAX = 16'sh7fff;      // Largest positive word
  localparam q_t Q_MIN = -16'sd32768;    // Most negative word

  // Input stream element, W(l) against x
  typedef struct packed {
    q_t weight;
    q_t operand;  // Sample x
  } in_pair_t;

  // Recurrent stream element, K/U against r then h
  typedef struct packed {
    q_t weight;
    q_t operand;  // Read vector or hidden state
  } rec_pair_t;

  // One activation result
  typedef struct packed {
    logic [IDX_W-1:0] index;  // Neuron l
    q_t               value;  // a(l)
  } gate_out_t;

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Clamp a wide signed value to the q_t range
  function automatic q_t sat_q(input logic signed [ACC_W-1:0] v);
    q_t r;
    if (v > Q_MAX) begin
      r = Q_MAX;
    end else if (v < Q_MIN) begin
      r = Q_MIN;
    end else begin
      r = v[Q_W-1:0];  // Fits, plain truncation
    end
    return r;
  endfunction

endpackage

`default_nettype wire
